//--- logic/datapath_consts.svh
// width macros for the execute stage datapath: data, ALU op, branch code, forwarding select

`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// datapath word width, fixed by the instruction set
`define DATA_W 16

// ALU operation code width
`define OP_W 4

// branch condition code width
`define BR_W 3

// forwarding source select width, one per operand
`define FWD_W 3

`endif

//--- logic/aluPkg.sv
// package aluPkg: ALU operation and branch condition enumerations

`default_nettype none

`include "datapath_consts.svh"

package aluPkg;

   // ALU operations, shift amounts come from the low four bits of B
   typedef enum logic [`OP_W-1:0] {
      aluAdd   = 4'h0,
      aluAnd   = 4'h1,
      aluOr    = 4'h2,
      aluXor   = 4'h3,
      aluSll   = 4'h4,
      aluSrl   = 4'h5,
      aluRol   = 4'h6,
      aluRor   = 4'h7,
      // {A[7:0], B[7:0]}
      aluSlbi  = 4'h8,
      aluBtr   = 4'h9,
      aluPassB = 4'ha
   } aluOpE;

   // branch conditions, the taken bit also drives set-style results
   typedef enum logic [`BR_W-1:0] {
      brNever  = 3'h0,
      brAlways = 3'h1,
      brEq     = 3'h2,
      brNe     = 3'h3,
      brLt     = 3'h4,
      brGe     = 3'h5,
      brLe     = 3'h6,
      brCarry  = 3'h7
   } brCondE;

endpackage

`default_nettype wire

//--- logic/fwdPkg.sv
// package fwdPkg: forwarding source enumeration for the execute operands

`default_nettype none

`include "datapath_consts.svh"

package fwdPkg;

   // where an operand comes from
   // ex* values sit in the execute/memory register, mem* in memory/writeback
   typedef enum logic [`FWD_W-1:0] {
      fwdNone    = 3'h0,
      fwdExAlu   = 3'h1,
      fwdExImm   = 3'h2,
      fwdExLink  = 3'h3,
      fwdMemAlu  = 3'h4,
      fwdMemImm  = 3'h5,
      fwdMemLink = 3'h6,
      fwdMemLoad = 3'h7
   } fwdSrcE;

endpackage

`default_nettype wire

//--- logic/operandForward.sv
// module operandForward: forwarded A and B operand selection and store data choice

`default_nettype none
`timescale 1ns/1ps

`include "datapath_consts.svh"

module operandForward (
   input  wire [`DATA_W-1:0] regA,
   input  wire [`DATA_W-1:0] regB,
   input  wire [`DATA_W-1:0] exAlu,
   input  wire [`DATA_W-1:0] exImm,
   input  wire [`DATA_W-1:0] exLink,
   input  wire [`DATA_W-1:0] memAlu,
   input  wire [`DATA_W-1:0] memImm,
   input  wire [`DATA_W-1:0] memLink,
   input  wire [`DATA_W-1:0] memLoad,
   input  wire fwdPkg::fwdSrcE fwdSelA,
   input  wire fwdPkg::fwdSrcE fwdSelB,
   input  wire storeFwd,
   input  wire loadFwd,
   input  wire [`DATA_W-1:0] wrtDataIn,
   output logic [`DATA_W-1:0] fwdA,
   output logic [`DATA_W-1:0] fwdB,
   output logic [`DATA_W-1:0] storeData
);

   import fwdPkg::*;

   // one mux shared by both operands, regVal is the fallback for fwdNone
   function automatic logic [`DATA_W-1:0] pickSrc(input fwdSrcE sel,
                                                  input logic [`DATA_W-1:0] regVal);
      logic [`DATA_W-1:0] picked;
      case (sel)
         fwdExAlu:   picked = exAlu;
         fwdExImm:   picked = exImm;
         fwdExLink:  picked = exLink;
         fwdMemAlu:  picked = memAlu;
         fwdMemImm:  picked = memImm;
         fwdMemLink: picked = memLink;
         fwdMemLoad: picked = memLoad;
         default:    picked = regVal;
      endcase
      return picked;
   endfunction

   always_comb begin
      fwdA = pickSrc(fwdSelA, regA);
      fwdB = pickSrc(fwdSelB, regB);
   end

   // store data follows forwarded B for a store hit
   // a load-to-store hit is resolved on the memory side, so take wrtDataIn then
   always_comb begin
      if (storeFwd && !loadFwd) begin
         storeData = fwdB;
      end else begin
         storeData = wrtDataIn;
      end
   end

endmodule

`default_nettype wire

//--- logic/alu.sv
// module alu: 16-bit ALU with operand inversion, carry-in, shifts, rotates and flags

`default_nettype none
`timescale 1ns/1ps

`include "datapath_consts.svh"

module alu (
   input  wire [`DATA_W-1:0] inA,
   input  wire [`DATA_W-1:0] inB,
   input  wire aluPkg::aluOpE op,
   input  wire invA,
   input  wire invB,
   input  wire cin,
   output logic [`DATA_W-1:0] result,
   output logic zero,
   output logic sign,
   output logic ofl,
   output logic carry
);

   import aluPkg::*;

   // operands after optional inversion
   logic [`DATA_W-1:0] opA;
   logic [`DATA_W-1:0] opB;

   // adder with its carry out on top
   logic [`DATA_W:0] sumWide;

   // rotate helpers, A doubled up so the wrapped bits fall in place
   logic [2*`DATA_W-1:0] rolWide;
   logic [2*`DATA_W-1:0] rorWide;

   // shift amount, low four bits of B
   logic [3:0] shAmt;

   // bit-reversed A
   logic [`DATA_W-1:0] revA;

   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;

   // subtract is invA with cin set, i.e. B - A
   assign sumWide = {1'b0, opA} + {1'b0, opB} + {{`DATA_W{1'b0}}, cin};

   assign shAmt   = opB[3:0];
   assign rolWide = {opA, opA} << shAmt;
   assign rorWide = {opA, opA} >> shAmt;

   always_comb begin
      for (int i = 0; i < `DATA_W; i++) begin
         revA[i] = opA[`DATA_W-1-i];
      end
   end

   always_comb begin
      case (op)
         aluAdd:   result = sumWide[`DATA_W-1:0];
         aluAnd:   result = opA & opB;
         aluOr:    result = opA | opB;
         aluXor:   result = opA ^ opB;
         aluSll:   result = opA << shAmt;
         aluSrl:   result = opA >> shAmt;
         aluRol:   result = rolWide[2*`DATA_W-1:`DATA_W];
         aluRor:   result = rorWide[`DATA_W-1:0];
         aluSlbi:  result = {opA[7:0], opB[7:0]};
         aluBtr:   result = revA;
         aluPassB: result = opB;
         // unused codes give zero
         default:  result = '0;
      endcase
   end

   // zero and sign straight off the result
   assign zero = (result == '0);
   assign sign = result[`DATA_W-1];

   // carry and overflow only mean something for the adder
   always_comb begin
      if (op == aluAdd) begin
         carry = sumWide[`DATA_W];
         // same-sign inputs producing an opposite-sign sum
         ofl   = (opA[`DATA_W-1] == opB[`DATA_W-1]) &&
                 (sumWide[`DATA_W-1] != opA[`DATA_W-1]);
      end else begin
         carry = 1'b0;
         ofl   = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- logic/branchCondition.sv
// module branchCondition: branch taken decision from ALU flags and the branch code

`default_nettype none
`timescale 1ns/1ps

module branchCondition (
   input  wire aluPkg::brCondE brCode,
   input  wire zero,
   input  wire sign,
   input  wire ofl,
   input  wire carry,
   output logic taken
);

   import aluPkg::*;

   // signed less-than after a compare
   logic lessThan;

   assign lessThan = sign ^ ofl;

   // same bit feeds conditional branches and set-style results
   always_comb begin
      case (brCode)
         brNever:  taken = 1'b0;
         brAlways: taken = 1'b1;
         brEq:     taken = zero;
         brNe:     taken = !zero;
         brLt:     taken = lessThan;
         brGe:     taken = !lessThan;
         brLe:     taken = lessThan || zero;
         brCarry:  taken = carry;
         default:  taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/pcSelect.sv
// module pcSelect: branch target, link value and next PC selection

`default_nettype none
`timescale 1ns/1ps

`include "datapath_consts.svh"

module pcSelect (
   input  wire [`DATA_W-1:0] incPC,
   input  wire [`DATA_W-1:0] aluOut,
   input  wire [`DATA_W-1:0] imm8,
   input  wire [`DATA_W-1:0] imm11,
   input  wire taken,
   input  wire immSel,
   input  wire baseAlu,
   input  wire aluJump,
   input  wire linkSel,
   input  wire holdPC,
   output logic [`DATA_W-1:0] nextPC,
   output logic [`DATA_W-1:0] linkPC
);

   // target adder operands
   logic [`DATA_W-1:0] baseVal;
   logic [`DATA_W-1:0] immVal;

   // base plus immediate, wraps at 16 bits
   logic [`DATA_W-1:0] targetPC;

   // target or fall-through depending on the branch outcome
   logic [`DATA_W-1:0] jumpPC;

   // register-relative jumps use the ALU as base
   assign baseVal = baseAlu ? aluOut : incPC;
   // imm11 for jumps, imm8 for branches
   assign immVal  = immSel ? imm11 : imm8;

   assign targetPC = baseVal + immVal;
   assign jumpPC   = taken ? targetPC : incPC;

   // link-style instructions save the return address
   assign linkPC = linkSel ? incPC : jumpPC;

   always_comb begin
      if (holdPC) begin
         nextPC = incPC;
      end else if (aluJump) begin
         // absolute jump straight from the ALU
         nextPC = aluOut;
      end else begin
         nextPC = jumpPC;
      end
   end

endmodule

`default_nettype wire

//--- logic/execStage.sv
// module execStage: execute stage top with req/ack handshake, result registers and datapath

`default_nettype none
`timescale 1ns/1ps

`include "datapath_consts.svh"

module execStage (
   input  wire clk,
   input  wire rstN,
   input  wire req,
   output logic ack,
   input  wire [`DATA_W-1:0] regA,
   input  wire [`DATA_W-1:0] regB,
   input  wire [`DATA_W-1:0] exAlu,
   input  wire [`DATA_W-1:0] exImm,
   input  wire [`DATA_W-1:0] exLink,
   input  wire [`DATA_W-1:0] memAlu,
   input  wire [`DATA_W-1:0] memImm,
   input  wire [`DATA_W-1:0] memLink,
   input  wire [`DATA_W-1:0] memLoad,
   input  wire [`DATA_W-1:0] wrtDataIn,
   input  wire [`DATA_W-1:0] incPC,
   input  wire [`DATA_W-1:0] imm8,
   input  wire [`DATA_W-1:0] imm11,
   input  wire fwdPkg::fwdSrcE fwdSelA,
   input  wire fwdPkg::fwdSrcE fwdSelB,
   input  wire storeFwd,
   input  wire loadFwd,
   input  wire stuSel,
   input  wire aluPkg::aluOpE op,
   input  wire invA,
   input  wire invB,
   input  wire cin,
   input  wire aluPkg::brCondE brCode,
   input  wire setOp,
   input  wire immSel,
   input  wire baseAlu,
   input  wire aluJump,
   input  wire linkSel,
   input  wire holdPC,
   output logic [`DATA_W-1:0] resultOut,
   output logic [`DATA_W-1:0] nextPC,
   output logic [`DATA_W-1:0] linkPC,
   output logic [`DATA_W-1:0] storeData
);

   // forwarded operands
   logic [`DATA_W-1:0] fwdA;
   logic [`DATA_W-1:0] fwdB;
   logic [`DATA_W-1:0] aluInB;

   // ALU result and flags
   logic [`DATA_W-1:0] aluOut;
   logic zero;
   logic sign;
   logic ofl;
   logic carry;
   logic taken;

   // combinational values waiting to be captured
   logic [`DATA_W-1:0] resultD;
   logic [`DATA_W-1:0] nextPCD;
   logic [`DATA_W-1:0] linkPCD;
   logic [`DATA_W-1:0] storeDataD;

   // new request seen while idle
   logic capture;

   operandForward fwdUnit (
      .regA(regA), .regB(regB),
      .exAlu(exAlu), .exImm(exImm), .exLink(exLink),
      .memAlu(memAlu), .memImm(memImm), .memLink(memLink), .memLoad(memLoad),
      .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
      .storeFwd(storeFwd), .loadFwd(loadFwd), .wrtDataIn(wrtDataIn),
      .fwdA(fwdA), .fwdB(fwdB), .storeData(storeDataD)
   );

   // store-with-update takes the raw register B, not the forwarded one
   assign aluInB = stuSel ? regB : fwdB;

   alu aluUnit (
      .inA(fwdA), .inB(aluInB), .op(op),
      .invA(invA), .invB(invB), .cin(cin),
      .result(aluOut),
      .zero(zero), .sign(sign), .ofl(ofl), .carry(carry)
   );

   branchCondition brUnit (
      .brCode(brCode),
      .zero(zero), .sign(sign), .ofl(ofl), .carry(carry),
      .taken(taken)
   );

   pcSelect pcUnit (
      .incPC(incPC), .aluOut(aluOut), .imm8(imm8), .imm11(imm11),
      .taken(taken), .immSel(immSel), .baseAlu(baseAlu),
      .aluJump(aluJump), .linkSel(linkSel), .holdPC(holdPC),
      .nextPC(nextPCD), .linkPC(linkPCD)
   );

   // set-style ops write the taken bit, zero-extended
   assign resultD = setOp ? {{(`DATA_W-1){1'b0}}, taken} : aluOut;

   assign capture = req && !ack;

   // two states, idle (ack low) and done (ack high)
   // rise on a fresh req, fall once req is seen low
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ack <= 1'b0;
      end else if (capture) begin
         ack <= 1'b1;
      end else if (ack && !req) begin
         ack <= 1'b0;
      end
   end

   // results load only on the idle-to-done edge and hold while ack is up
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         resultOut <= '0;
         nextPC    <= '0;
         linkPC    <= '0;
         storeData <= '0;
      end else if (capture) begin
         resultOut <= resultD;
         nextPC    <= nextPCD;
         linkPC    <= linkPCD;
         storeData <= storeDataD;
      end
   end

endmodule

`default_nettype wire

//--- verif/execStageTb.sv
// execStageTb: testbench for execStage with LFSR stimulus, reference model and assertions

`default_nettype none
`timescale 1ns/1ps

`include "datapath_consts.svh"

module execStageTb;

   import aluPkg::*;
   import fwdPkg::*;

   // cycles allowed for one ack edge, and for the whole run
   localparam int waitLimit = 16;
   localparam int runLimit  = 20000;

   logic clk;
   logic rstN;
   logic req;
   logic ack;
   logic [`DATA_W-1:0] regA;
   logic [`DATA_W-1:0] regB;
   logic [`DATA_W-1:0] exAlu;
   logic [`DATA_W-1:0] exImm;
   logic [`DATA_W-1:0] exLink;
   logic [`DATA_W-1:0] memAlu;
   logic [`DATA_W-1:0] memImm;
   logic [`DATA_W-1:0] memLink;
   logic [`DATA_W-1:0] memLoad;
   logic [`DATA_W-1:0] wrtDataIn;
   logic [`DATA_W-1:0] incPC;
   logic [`DATA_W-1:0] imm8;
   logic [`DATA_W-1:0] imm11;
   fwdSrcE fwdSelA;
   fwdSrcE fwdSelB;
   aluOpE op;
   brCondE brCode;
   logic storeFwd;
   logic loadFwd;
   logic stuSel;
   logic invA;
   logic invB;
   logic cin;
   logic setOp;
   logic immSel;
   logic baseAlu;
   logic aluJump;
   logic linkSel;
   logic holdPC;
   logic [`DATA_W-1:0] resultOut;
   logic [`DATA_W-1:0] nextPC;
   logic [`DATA_W-1:0] linkPC;
   logic [`DATA_W-1:0] storeData;

   // model outputs for the transaction in flight
   logic [`DATA_W-1:0] expResult;
   logic [`DATA_W-1:0] expNext;
   logic [`DATA_W-1:0] expLink;
   logic [`DATA_W-1:0] expStore;

   logic [31:0] lfsrState = 32'hf5d;
   int errCount = 0;
   int checkCount = 0;
   int errBase;
   int checkBase;
   logic timeoutSeen = 1'b0;

   execStage UUT (
      .clk(clk), .rstN(rstN), .req(req), .ack(ack),
      .regA(regA), .regB(regB),
      .exAlu(exAlu), .exImm(exImm), .exLink(exLink),
      .memAlu(memAlu), .memImm(memImm), .memLink(memLink), .memLoad(memLoad),
      .wrtDataIn(wrtDataIn), .incPC(incPC), .imm8(imm8), .imm11(imm11),
      .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
      .storeFwd(storeFwd), .loadFwd(loadFwd), .stuSel(stuSel),
      .op(op), .invA(invA), .invB(invB), .cin(cin), .brCode(brCode),
      .setOp(setOp), .immSel(immSel), .baseAlu(baseAlu),
      .aluJump(aluJump), .linkSel(linkSel), .holdPC(holdPC),
      .resultOut(resultOut), .nextPC(nextPC), .linkPC(linkPC), .storeData(storeData)
   );

   always #20 clk = ~clk;

   // handshake rules, checked on every edge out of reset
   ackRises: assert property (@(posedge clk) disable iff (!rstN) req && !ack |=> ack)
      else begin
         errCount++;
         $display("ack did not rise one cycle after req was sampled high");
      end
   holdStable: assert property (@(posedge clk) disable iff (!rstN)
         ack && req |=> ack && $stable(resultOut) && $stable(nextPC) &&
                        $stable(linkPC) && $stable(storeData))
      else begin
         errCount++;
         $display("ack dropped or results changed while req was still held");
      end
   ackFalls: assert property (@(posedge clk) disable iff (!rstN) ack && !req |=> !ack)
      else begin
         errCount++;
         $display("ack did not fall one cycle after req dropped");
      end

   // Galois LFSR, one step per bit taken, up to 16 bits
   function automatic logic [15:0] randBits(input int n);
      logic [15:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[14:0], lfsrState[0]};
         lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
      end
      return val;
   endfunction

   function automatic logic [15:0] pickModel(input fwdSrcE sel, input logic [15:0] regVal);
      case (sel)
         fwdExAlu:   return exAlu;
         fwdExImm:   return exImm;
         fwdExLink:  return exLink;
         fwdMemAlu:  return memAlu;
         fwdMemImm:  return memImm;
         fwdMemLink: return memLink;
         fwdMemLoad: return memLoad;
         default:    return regVal;
      endcase
   endfunction

   // returns {carry, ofl, result}
   function automatic logic [17:0] modelAlu(input logic [15:0] a, input logic [15:0] b,
                                            input aluOpE opc, input logic ia,
                                            input logic ib, input logic ci);
      logic [15:0] x;
      logic [15:0] y;
      logic [15:0] r;
      logic [16:0] s;
      logic [1:0] fl;
      int n;
      x = ia ? ~a : a;
      y = ib ? ~b : b;
      n = y[3:0];
      s = x + y + ci;
      r = 16'h0;
      case (opc)
         aluAdd:   r = s[15:0];
         aluAnd:   r = x & y;
         aluOr:    r = x | y;
         aluXor:   r = x ^ y;
         aluSll:   r = x << n;
         aluSrl:   r = x >> n;
         aluRol:   r = (x << n) | (x >> (16 - n));
         aluRor:   r = (x >> n) | (x << (16 - n));
         aluSlbi:  r = (x << 8) | (y & 16'h00ff);
         aluBtr:   for (int i = 0; i < 16; i++) r[i] = x[15-i];
         aluPassB: r = y;
         default:  r = 16'h0;
      endcase
      // flags from the adder only
      fl = 2'b00;
      if (opc == aluAdd) begin
         fl = {s[16], (x[15] == y[15]) && (s[15] != x[15])};
      end
      return {fl, r};
   endfunction

   function automatic logic modelTaken(input brCondE code, input logic z, input logic s,
                                       input logic v, input logic c);
      case (code)
         brAlways: return 1'b1;
         brEq:     return z;
         brNe:     return !z;
         brLt:     return s ^ v;
         brGe:     return !(s ^ v);
         brLe:     return (s ^ v) || z;
         brCarry:  return c;
         default:  return 1'b0;
      endcase
   endfunction

   task automatic computeExpected();
      logic [15:0] fa;
      logic [15:0] fb;
      logic [15:0] target;
      logic [15:0] jump;
      logic [17:0] res;
      logic tk;
      fa = pickModel(fwdSelA, regA);
      fb = pickModel(fwdSelB, regB);
      res = modelAlu(fa, stuSel ? regB : fb, op, invA, invB, cin);
      tk = modelTaken(brCode, res[15:0] == 16'h0, res[15], res[16], res[17]);
      expResult = setOp ? {15'h0, tk} : res[15:0];
      expStore = (storeFwd && !loadFwd) ? fb : wrtDataIn;
      target = (baseAlu ? res[15:0] : incPC) + (immSel ? imm11 : imm8);
      jump = tk ? target : incPC;
      expLink = linkSel ? incPC : jump;
      expNext = holdPC ? incPC : (aluJump ? res[15:0] : jump);
   endtask

   task automatic checkVal(input string name, input logic [15:0] expV, input logic [15:0] actV);
      checkCount++;
      assert (actV === expV) else begin
         errCount++;
         $display("error %s expected %h actual %h", name, expV, actV);
      end
   endtask

   // random buses, all controls back to a plain add
   task automatic baseInputs();
      regA = randBits(16);
      regB = randBits(16);
      exAlu = randBits(16);
      exImm = randBits(16);
      exLink = randBits(16);
      memAlu = randBits(16);
      memImm = randBits(16);
      memLink = randBits(16);
      memLoad = randBits(16);
      wrtDataIn = randBits(16);
      incPC = randBits(16);
      imm8 = randBits(16);
      imm11 = randBits(16);
      fwdSelA = fwdNone;
      fwdSelB = fwdNone;
      op = aluAdd;
      brCode = brNever;
      {storeFwd, loadFwd, stuSel, invA, invB, cin} = '0;
      {setOp, immSel, baseAlu, aluJump, linkSel, holdPC} = '0;
   endtask

   // polls 2 ns after each edge until ack reaches level
   task automatic waitAck(input logic level, output int cycles);
      cycles = 0;
      while (ack !== level && !timeoutSeen) begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles >= waitLimit && ack !== level) begin
            if (level) begin
               $display("timeout: ack never rose after req");
            end else begin
               $display("timeout: ack never fell after req dropped");
            end
            timeoutSeen = 1'b1;
         end
      end
   endtask

   // one four-phase transaction, req held for holdCycles extra edges
   task automatic runTxn(input int holdCycles);
      int cycles;
      computeExpected();
      req = 1'b1;
      waitAck(1'b1, cycles);
      if (!timeoutSeen) begin
         assert (cycles == 1) else begin
            errCount++;
            $display("ack took %0d cycles to rise instead of one", cycles);
         end
         checkVal("resultOut", expResult, resultOut);
         checkVal("nextPC", expNext, nextPC);
         checkVal("linkPC", expLink, linkPC);
         checkVal("storeData", expStore, storeData);
         // new operands under a held req must not reach the results
         for (int h = 0; h < holdCycles; h++) begin
            regA = randBits(16);
            regB = randBits(16);
            incPC = randBits(16);
            wrtDataIn = randBits(16);
            @(posedge clk);
            #2;
         end
         checkVal("resultOut", expResult, resultOut);
         req = 1'b0;
         waitAck(1'b0, cycles);
      end
   endtask

   task automatic startTest();
      errBase = errCount;
      checkBase = checkCount;
   endtask

   task automatic endTest(input string name);
      $display("test %s done: %0d checks, %0d errors", name,
               checkCount - checkBase, errCount - errBase);
   endtask

   // fails the run on a stuck handshake or an overlong run
   initial begin
      int cycles;
      cycles = 0;
      while (!timeoutSeen && cycles < runLimit) begin
         @(posedge clk or posedge timeoutSeen);
         cycles++;
      end
      if (!timeoutSeen) begin
         $display("timeout: run went past %0d cycles", runLimit);
      end
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      // {A, B} pairs for B - A that set and clear zero, sign, overflow and carry
      logic [31:0] brPairs [5];
      brPairs = '{32'h0005_0005, 32'h0005_0003, 32'h0003_0005,
                  32'h0001_8000, 32'hffff_7fff};
      clk = 1'b0;
      rstN = 1'b0;
      req = 1'b0;
      baseInputs();

      startTest();
      for (int c = 0; c < 4; c++) begin
         @(posedge clk);
         #2;
         checkVal("ack", 16'h0, {15'h0, ack});
         checkVal("resultOut", 16'h0, resultOut);
         checkVal("nextPC", 16'h0, nextPC);
         checkVal("linkPC", 16'h0, linkPC);
         checkVal("storeData", 16'h0, storeData);
      end
      rstN = 1'b1;
      @(posedge clk);
      #2;
      checkVal("ack", 16'h0, {15'h0, ack});
      runTxn(0);
      baseInputs();
      runTxn(3);
      endTest("handshake");

      startTest();
      for (int k = 0; k <= 10; k++) begin
         for (int r = 0; r < 8; r++) begin
            baseInputs();
            op = aluOpE'(k);
            invA = (randBits(1) != 16'h0);
            invB = (randBits(1) != 16'h0);
            cin = (randBits(1) != 16'h0);
            runTxn(randBits(1));
         end
      end
      endTest("aluOps");

      startTest();
      for (int s = 0; s < 8; s++) begin
         baseInputs();
         op = aluPassB;
         fwdSelA = fwdSrcE'(s);
         fwdSelB = fwdSrcE'(s);
         runTxn(0);
         baseInputs();
         fwdSelA = fwdSrcE'(s);
         fwdSelB = fwdSrcE'(7 - s);
         runTxn(0);
      end
      // raw register B ahead of a forward hit
      baseInputs();
      op = aluPassB;
      fwdSelB = fwdExAlu;
      stuSel = 1'b1;
      runTxn(0);
      for (int m = 0; m < 4; m++) begin
         baseInputs();
         fwdSelB = fwdSrcE'(randBits(3));
         {storeFwd, loadFwd} = m[1:0];
         runTxn(0);
      end
      endTest("forwarding");

      startTest();
      for (int b = 0; b < 8; b++) begin
         for (int p = 0; p < 6; p++) begin
            baseInputs();
            if (p < 5) begin
               {regA, regB} = brPairs[p];
            end
            brCode = brCondE'(b);
            invA = 1'b1;
            cin = 1'b1;
            setOp = 1'b1;
            runTxn(0);
         end
      end
      endTest("branchSet");

      startTest();
      for (int combo = 0; combo < 32; combo++) begin
         for (int t = 0; t < 2; t++) begin
            baseInputs();
            {immSel, baseAlu, aluJump, linkSel, holdPC} = combo[4:0];
            brCode = t ? brAlways : brNever;
            runTxn(0);
         end
      end
      endTest("pcSelect");

      $display("all tests done: %0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0 && !timeoutSeen) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/aluPkg.sv
logic/fwdPkg.sv
logic/operandForward.sv
logic/alu.sv
logic/branchCondition.sv
logic/pcSelect.sv
logic/execStage.sv
verif/execStageTb.sv
